// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_periph
FILELIST  ?= spi_periph_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= SOME TESTS FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cs_router.sv
`timescale 1ns/1ns

module cs_router
  import spi_periph_pkg::*;
(
  input  logic     cs,
  input  logic     rst_n,
  input  logic     ss_sync,
  input  logic     special_sync,
  input  reg_val_t mux_reg,
  output reg_val_t periph_cs_n
);

  // ss_n spread over every peripheral bit
  reg_val_t ss_vec;

  // next value of the outputs
  reg_val_t cs_next;

  assign ss_vec = {$bits(reg_val_t){ss_sync}};

  // active low both ways
  // bit is low only when selected and ss_n is low
  always_comb
  begin
    if (special_sync)
      cs_next = ~(mux_reg & ~ss_vec);
    else
      // register mode, keep everyone off the bus
      cs_next = '1;
  end

  // one flop stage
  // outputs go straight to pins, no decode glitches
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      periph_cs_n <= '1;
    else
      periph_cs_n <= cs_next;
  end

endmodule

// File: reg_bank.sv
`timescale 1ns/1ns

module reg_bank
  import spi_periph_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  logic      wr_valid,
  input  reg_addr_t wr_addr,
  input  reg_val_t  wr_data,
  output reg_val_t  led,
  output reg_val_t  mux_reg,
  output dac_ctl_t  dac_ctl
);

  // write strobes per register
  logic wr_led;
  logic wr_mux;
  logic wr_dac;

  // address decode
  // unknown addresses fall through and hit nothing
  assign wr_led = wr_valid && (wr_addr == ADDR_LED);
  assign wr_mux = wr_valid && (wr_addr == ADDR_MUX);
  assign wr_dac = wr_valid && (wr_addr == ADDR_DAC);

  // led register
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      led <= '0;
    else if (wr_led)
      led <= wr_data;
  end

  // chip select mux, one bit per peripheral
  // set bit means the peripheral follows ss_n
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      mux_reg <= '0;
    else if (wr_mux)
      mux_reg <= wr_data;
  end

  // dac control
  // only the low nibble of the value is kept
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      dac_ctl <= '0;
    else if (wr_dac)
      dac_ctl <= wr_data[$bits(dac_ctl_t)-1:0];
  end

endmodule

// File: spi_frame_rx.sv
`timescale 1ns/1ns

module spi_frame_rx
  import spi_periph_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  logic      sclk,
  input  logic      ss_n,
  input  logic      mosi,
  input  logic      special_n,
  output logic      wr_valid,
  output reg_addr_t wr_addr,
  output reg_val_t  wr_data,
  output logic      frame_err,
  output logic      ss_sync,
  output logic      special_sync
);

  // synchroniser chains with index 0 as the first flop
  logic [SYNC_STAGES-1:0] sclk_pipe;
  logic [SYNC_STAGES-1:0] ss_pipe;
  logic [SYNC_STAGES-1:0] mosi_pipe;
  logic [SYNC_STAGES-1:0] special_pipe;

  logic      sclk_sync;
  logic      mosi_sync;
  logic      sclk_d;
  logic      ss_d;
  logic      sclk_fall;
  logic      ss_fall;
  logic      ss_rise;
  logic      special_lat;
  rx_state_t state;
  frame_t    shift_reg;
  bit_cnt_t  bit_cnt;

  // pins are asynchronous to cs
  // reset to the idle levels so no false edge follows reset
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_pipe    <= '0;
      ss_pipe      <= '1;
      mosi_pipe    <= '0;
      special_pipe <= '1;
    end
    else
    begin
      sclk_pipe    <= {sclk_pipe[SYNC_STAGES-2:0], sclk};
      ss_pipe      <= {ss_pipe[SYNC_STAGES-2:0], ss_n};
      mosi_pipe    <= {mosi_pipe[SYNC_STAGES-2:0], mosi};
      special_pipe <= {special_pipe[SYNC_STAGES-2:0], special_n};
    end
  end

  assign sclk_sync    = sclk_pipe[SYNC_STAGES-1];
  assign ss_sync      = ss_pipe[SYNC_STAGES-1];
  assign mosi_sync    = mosi_pipe[SYNC_STAGES-1];
  assign special_sync = special_pipe[SYNC_STAGES-1];

  // previous levels for edge detect
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_d <= 1'b0;
      ss_d   <= 1'b1;
    end
    else
    begin
      sclk_d <= sclk_sync;
      ss_d   <= ss_sync;
    end
  end

  assign sclk_fall = sclk_d & ~sclk_sync;
  assign ss_fall   = ss_d & ~ss_sync;
  assign ss_rise   = ~ss_d & ss_sync;

  // frame fsm with registered pulses
  // so they land one cycle after the synchronised edge
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      state       <= RX_IDLE;
      bit_cnt     <= '0;
      special_lat <= 1'b1;
      wr_valid    <= 1'b0;
      frame_err   <= 1'b0;
    end
    else
    begin
      wr_valid  <= 1'b0;
      frame_err <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          if (ss_fall)
          begin
            state       <= RX_SHIFT;
            bit_cnt     <= '0;
            special_lat <= special_sync;
          end
        end
        RX_SHIFT:
        begin
          // any pass-through level seen in the frame spoils it
          special_lat <= special_lat | special_sync;
          if (ss_rise)
          begin
            state <= RX_IDLE;
            if (!special_lat)
            begin
              if (bit_cnt == bit_cnt_t'(FRAME_BITS))
                wr_valid <= 1'b1;
              else
                frame_err <= 1'b1;
            end
          end
          else if (sclk_fall && bit_cnt != '1)
          begin
            // saturates at 31 which still reads as wrong
            bit_cnt <= bit_cnt + bit_cnt_t'(1);
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // payload shift register, msb first
  always_ff @(posedge cs)
  begin
    if (state == RX_SHIFT && sclk_fall && !ss_rise)
      shift_reg <= {shift_reg[FRAME_BITS-2:0], mosi_sync};
  end

  // shift reg is frozen in idle so the split is stable at wr_valid
  assign wr_addr = shift_reg[FRAME_BITS-1:FRAME_BITS/2];
  assign wr_data = shift_reg[FRAME_BITS/2-1:0];

endmodule

// File: spi_periph_pkg.sv
package spi_periph_pkg;

  // bits in one spi frame, address byte then value byte
  localparam int unsigned FRAME_BITS = 16;

  // depth of the pin synchronisers
  localparam int unsigned SYNC_STAGES = 2;

  // register address, high byte of the frame
  typedef logic [7:0] reg_addr_t;

  // register value, low byte of the frame
  // also the width of the led and mux registers
  typedef logic [7:0] reg_val_t;

  // dac control, bit 0 ldac, bit 1 rst,
  // bit 2 uni_bip_a, bit 3 uni_bip_b
  typedef logic [3:0] dac_ctl_t;

  // one whole frame as shifted in, msb first
  typedef logic [FRAME_BITS-1:0] frame_t;

  // one bit wider than needed for 16
  // so overlong frames stay visible
  typedef logic [4:0] bit_cnt_t;

  // register map
  localparam reg_addr_t ADDR_LED = 8'd7;
  localparam reg_addr_t ADDR_MUX = 8'd8;
  localparam reg_addr_t ADDR_DAC = 8'd9;

  // receiver fsm
  typedef enum logic {
    RX_IDLE,
    RX_SHIFT
  } rx_state_t;

endpackage

// File: spi_periph_properties.sv
`timescale 1ns/1ns

module spi_periph_properties
  import spi_periph_pkg::*;
(
  input logic     cs,
  input logic     rst_n,
  input logic     wr_valid,
  input logic     frame_err,
  input logic     special_sync,
  input reg_val_t periph_cs_n
);

  // a frame ends in a write or an error, never both
  a_pulse_exclusive: assert property (@(posedge cs) disable iff (!rst_n)
    !(wr_valid && frame_err))
    else $error("wr_valid and frame_err high in the same cycle");

  // one write per frame
  a_wr_single: assert property (@(posedge cs) disable iff (!rst_n)
    wr_valid |=> !wr_valid)
    else $error("wr_valid high for two cycles in a row");

  // register mode keeps every peripheral deselected
  a_reg_mode_idle: assert property (@(posedge cs) disable iff (!rst_n)
    !special_sync |=> (periph_cs_n == '1))
    else $error("periph_cs_n active while in register mode");

  // first cycle out of reset
  a_reset_values: assert property (@(posedge cs)
    $rose(rst_n) |-> (!wr_valid && !frame_err && periph_cs_n == '1))
    else $error("outputs not at reset values after reset");

endmodule

// watches the receiver pulses and the router output inside the top
bind spi_periph_top spi_periph_properties u_props (
  .cs           (cs),
  .rst_n        (rst_n),
  .wr_valid     (wr_valid),
  .frame_err    (frame_err),
  .special_sync (special_sync),
  .periph_cs_n  (periph_cs_n)
);

// File: spi_periph_top.f
spi_periph_pkg.sv
spi_frame_rx.sv
reg_bank.sv
cs_router.sv
spi_periph_top.sv
spi_periph_properties.sv
tb_spi_periph.sv

// File: spi_periph_top.sv
`timescale 1ns/1ns

module spi_periph_top
  import spi_periph_pkg::*;
(
  input  logic     cs,
  input  logic     rst_n,
  input  logic     sclk,
  input  logic     ss_n,
  input  logic     mosi,
  input  logic     special_n,
  output reg_val_t led,
  output dac_ctl_t dac_ctl,
  output reg_val_t periph_cs_n,
  output logic     frame_err
);

  // receiver to register bank
  logic      wr_valid;
  reg_addr_t wr_addr;
  reg_val_t  wr_data;

  // synchronised pin levels for the router
  logic      ss_sync;
  logic      special_sync;

  // register bank to router
  reg_val_t  mux_reg;

  // only block that touches the raw spi pins
  spi_frame_rx u_rx (
    .cs           (cs),
    .rst_n        (rst_n),
    .sclk         (sclk),
    .ss_n         (ss_n),
    .mosi         (mosi),
    .special_n    (special_n),
    .wr_valid     (wr_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .frame_err    (frame_err),
    .ss_sync      (ss_sync),
    .special_sync (special_sync)
  );

  reg_bank u_regs (
    .cs       (cs),
    .rst_n    (rst_n),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .led      (led),
    .mux_reg  (mux_reg),
    .dac_ctl  (dac_ctl)
  );

  cs_router u_router (
    .cs           (cs),
    .rst_n        (rst_n),
    .ss_sync      (ss_sync),
    .special_sync (special_sync),
    .mux_reg      (mux_reg),
    .periph_cs_n  (periph_cs_n)
  );

endmodule

// File: spi_periph_trace.txt
# R exp_led exp_dac exp_periph_cs_n | P exp_periph_cs_n (special_n high, ss_n low)
# W nbits(dec) frame exp_led exp_dac exp_frame_err_count(dec), special_n low, values hex
R 00 0 ff
P ff
W 16 07a5 a5 0 0
W 16 0981 a5 1 0
W 16 093c a5 c 0
W 16 0812 a5 c 0
P ed
# unknown addresses
W 16 2a55 a5 c 0
W 16 0655 a5 c 0
W 16 ff00 a5 c 0
# short and long frames
W 15 07ff a5 c 1
W 17 1095a a5 c 2
P ed
W 16 08f0 a5 c 2
P 0f
W 16 0700 00 c 2
W 16 0800 00 c 2
P ff
W 16 0801 00 c 2
P fe
W 16 0780 80 c 2
W 16 09f5 80 5 2
W 8 07 80 5 3
W 0 0 80 5 4
W 16 08ff 80 5 4
P 00
W 16 0880 80 5 4
P 7f
# reset clears the bank
R 00 0 ff
P ff
W 16 0733 33 0 4
W 16 0966 33 6 4

// File: tb_spi_periph.sv
`timescale 1ns/1ns

module tb_spi_periph
  import spi_periph_pkg::*;
;

  // 17 bits at the slowest bit time, plus setup and margin, in ns
  localparam int WORST_FRAME_NS = (17 * 11 + 40) * 4;

  logic     cs;
  logic     rst_n;
  logic     sclk;
  logic     ss_n;
  logic     mosi;
  logic     special_n;
  reg_val_t led;
  dac_ctl_t dac_ctl;
  reg_val_t periph_cs_n;
  logic     frame_err;

  // trace lines, and the state the registers should hold now
  string    lines[$];
  int       n_lines = 0;
  int       err_count = 0;
  reg_val_t cur_led;
  dac_ctl_t cur_dac;
  int       cur_err;

  spi_periph_top u_dut (
    .cs          (cs),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .ss_n        (ss_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .periph_cs_n (periph_cs_n),
    .frame_err   (frame_err)
  );

  initial
  begin
    cs = 1'b0;
    forever #2 cs = ~cs;
  end

  // running count of error pulses
  always @(posedge cs)
  begin
    if (rst_n && frame_err)
      err_count <= err_count + 1;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_reg_val(input string name, input reg_val_t exp_val,
                               input reg_val_t act_val);
    if (exp_val !== act_val)
      fail_run($sformatf("Fail %s expected %h actual %h", name, exp_val, act_val));
  endtask

  task automatic check_dac(input string name, input dac_ctl_t exp_val,
                           input dac_ctl_t act_val);
    if (exp_val !== act_val)
      fail_run($sformatf("Fail %s dac_ctl expected %h actual %h", name, exp_val, act_val));
  endtask

  task automatic check_err_count(input string name, input int exp_val, input int act_val);
    if (exp_val != act_val)
      fail_run($sformatf("Fail %s frame_err count expected %0d actual %0d",
                         name, exp_val, act_val));
  endtask

  // inputs change 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    wait_cycles(2);
    rst_n = 1'b1;
  endtask

  // msb first, shifted on the falling sclk
  // periph_cs_n checked against exp_cs while ss_n is low
  task automatic send_frame(input string name, input int nbits,
                            input logic [31:0] value, input reg_val_t exp_cs);
    int i;
    int gap;
    ss_n = 1'b0;
    wait_cycles(4);
    check_reg_val({name, " periph_cs_n"}, exp_cs, periph_cs_n);
    for (i = nbits - 1; i >= 0; i--)
    begin
      mosi = value[i];
      gap  = int'($urandom % 4);
      sclk = 1'b1;
      wait_cycles(4);
      sclk = 1'b0;
      wait_cycles(4 + gap);
      check_reg_val({name, " periph_cs_n"}, exp_cs, periph_cs_n);
    end
    wait_cycles(4);
    ss_n = 1'b1;
  endtask

  // register mode frame, router must stay quiet
  task automatic run_write(input string name, input int nbits, input logic [31:0] value,
                           input reg_val_t e_led, input dac_ctl_t e_dac, input int e_err);
    special_n = 1'b0;
    wait_cycles(4);
    send_frame(name, nbits, value, 8'hff);
    wait_cycles(10);
    check_reg_val({name, " led"}, e_led, led);
    check_dac(name, e_dac, dac_ctl);
    check_err_count(name, e_err, err_count);
    check_reg_val({name, " periph_cs_n"}, 8'hff, periph_cs_n);
    cur_led = e_led;
    cur_dac = e_dac;
    cur_err = e_err;
  endtask

  // pass-through, nothing in the bank may move
  task automatic run_pass(input string name, input reg_val_t e_cs);
    special_n = 1'b1;
    wait_cycles(4);
    send_frame(name, 16, 32'h0000_a55a, e_cs);
    wait_cycles(10);
    check_reg_val({name, " periph_cs_n after ss_n"}, 8'hff, periph_cs_n);
    check_reg_val({name, " led"}, cur_led, led);
    check_dac(name, cur_dac, dac_ctl);
    check_err_count(name, cur_err, err_count);
  endtask

  task automatic load_trace();
    int    fd;
    string line;
    fd = $fopen("spi_periph_trace.txt", "r");
    if (fd == 0)
      fail_run("cannot open trace file spi_periph_trace.txt");
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) > 0)
        lines.push_back(line);
    end
    $fclose(fd);
    n_lines = lines.size();
  endtask

  // ends the run if the trace stalls
  initial
  begin
    wait (n_lines > 0);
    #(n_lines * WORST_FRAME_NS * 2);
    fail_run("watchdog expired before the trace finished");
  end

  initial
  begin
    int          n_steps;
    int          nf;
    int          nbits;
    int          e_err;
    byte         kind;
    logic [31:0] value;
    reg_val_t    e_led;
    reg_val_t    e_cs;
    dac_ctl_t    e_dac;
    string       name;
    rst_n     = 1'b0;
    sclk      = 1'b0;
    ss_n      = 1'b1;
    mosi      = 1'b0;
    special_n = 1'b1;
    cur_led   = '0;
    cur_dac   = '0;
    cur_err   = 0;
    n_steps   = 0;
    void'($urandom(32'h2fdd_ffd7));
    load_trace();
    apply_reset();
    foreach (lines[ln])
    begin
      kind = (lines[ln].len() > 0) ? lines[ln].getc(0) : "#";
      name = $sformatf("line %0d %c", ln + 1, kind);
      // comments and blank lines
      if (kind == "#" || kind == "\n" || kind == "\r" || kind == " ")
        continue;
      n_steps++;
      if (kind == "W")
      begin
        nf = $sscanf(lines[ln], "%c %d %h %h %h %d", kind, nbits, value, e_led, e_dac, e_err);
        if (nf != 6)
          fail_run($sformatf("malformed write step on trace line %0d", ln + 1));
        run_write(name, nbits, value, e_led, e_dac, e_err);
      end
      else if (kind == "P")
      begin
        nf = $sscanf(lines[ln], "%c %h", kind, e_cs);
        if (nf != 2)
          fail_run($sformatf("malformed pass step on trace line %0d", ln + 1));
        run_pass(name, e_cs);
      end
      else if (kind == "R")
      begin
        nf = $sscanf(lines[ln], "%c %h %h %h", kind, e_led, e_dac, e_cs);
        if (nf != 4)
          fail_run($sformatf("malformed reset step on trace line %0d", ln + 1));
        apply_reset();
        check_reg_val({name, " led"}, e_led, led);
        check_dac(name, e_dac, dac_ctl);
        check_reg_val({name, " periph_cs_n"}, e_cs, periph_cs_n);
        cur_led = e_led;
        cur_dac = e_dac;
      end
      else
        fail_run($sformatf("unknown step kind on trace line %0d", ln + 1));
    end
    if (n_steps == 0)
      fail_run("trace file held no steps");
    else
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule
